//--- design/cciPkg.sv
// coherent link sniffer shared definitions
// request encodings, violation kind map, counter and APB sizing
package cciPkg;

   // line count of a request, encoded as lines minus one
   typedef enum logic [1:0] {
      len1 = 2'd0,
      len2 = 2'd1,
      len3 = 2'd2,
      len4 = 2'd3
   } reqLen;

   // read types belong on channel 0, write types on channel 1
   typedef enum logic [3:0] {
      rdLineI = 4'h0,
      rdLineS = 4'h1,
      wrLineI = 4'h2,
      wrLineM = 4'h3
   } reqType;

   // cache-line address width
   localparam int ADDR_W = 42;

   // violation kinds, one counter each
   localparam int NUM_KINDS = 10;

   // channel 0 kinds
   localparam int rdLen3 = 0;
   localparam int rdAlign = 1;
   localparam int rdOverflow = 2;
   localparam int rdInReset = 3;

   // channel 1 kinds, wrLen3 is the base of the write pulse vector
   localparam int wrLen3 = 4;
   localparam int wrAlign = 5;
   localparam int wrSop = 6;
   localparam int wrOverflow = 7;
   localparam int wrInReset = 8;
   localparam int wrBurstCut = 9;

   // counters saturate at all ones
   localparam int CNT_W = 8;

   // byte address, counter k at 4*k
   localparam int APB_AW = 6;

endpackage

//--- design/cciSniffer.sv
// coherent link request sniffer top
// read and write rule checkers feeding an APB counter bank
`timescale 1ns/1ns

module cciSniffer (
   input  logic                        clk,
   input  logic                        rst,
   // channel 0, reads
   input  logic                        c0Valid,
   input  cciPkg::reqType              c0Type,
   input  cciPkg::reqLen               c0Len,
   input  logic [cciPkg::ADDR_W-1:0]   c0Addr,
   input  logic                        c0Full,
   // channel 1, writes
   input  logic                        c1Valid,
   input  cciPkg::reqType              c1Type,
   input  cciPkg::reqLen               c1Len,
   input  logic [cciPkg::ADDR_W-1:0]   c1Addr,
   input  logic                        c1Sop,
   input  logic                        c1Full,
   // link soft reset, observed only
   input  logic                        softReset,
   // counter access
   input  logic [cciPkg::APB_AW-1:0]   paddr,
   input  logic                        psel,
   input  logic                        penable,
   input  logic                        pwrite,
   input  logic [31:0]                 pwdata,
   output logic [31:0]                 prdata,
   output logic                        pready,
   output logic                        pslverr,
   output logic                        alarm
);

   logic [3:0] rdViol;
   logic [5:0] wrViol;

   readReqRules readReqRules_i (
      .clk       (clk),
      .rst       (rst),
      .c0Valid   (c0Valid),
      .c0Type    (c0Type),
      .c0Len     (c0Len),
      .c0Addr    (c0Addr),
      .c0Full    (c0Full),
      .softReset (softReset),
      .rdViol    (rdViol)
   );

   writeBeatTracker writeBeatTracker_i (
      .clk       (clk),
      .rst       (rst),
      .c1Valid   (c1Valid),
      .c1Type    (c1Type),
      .c1Len     (c1Len),
      .c1Addr    (c1Addr),
      .c1Sop     (c1Sop),
      .c1Full    (c1Full),
      .softReset (softReset),
      .wrViol    (wrViol)
   );

   // write kinds sit above the read kinds
   violationCounters violationCounters_i (
      .clk     (clk),
      .rst     (rst),
      .viol    ({wrViol, rdViol}),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .alarm   (alarm)
   );

endmodule

//--- design/readReqRules.sv
// channel 0 read request checker
// flags len3, misalignment, overflow and traffic during link soft reset
`timescale 1ns/1ns

module readReqRules (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        c0Valid,
   input  cciPkg::reqType              c0Type,
   input  cciPkg::reqLen               c0Len,
   input  logic [cciPkg::ADDR_W-1:0]   c0Addr,
   input  logic                        c0Full,
   input  logic                        softReset,
   output logic [3:0]                  rdViol
);

   import cciPkg::*;

   logic isRead;
   logic lenErr;
   logic alignErr;
   logic overflowErr;
   logic inResetErr;

   // only read types are subject to the length rules
   assign isRead = c0Valid && ((c0Type == rdLineI) || (c0Type == rdLineS));

   // 3-line reads are not allowed
   assign lenErr = isRead && (c0Len == len3);

   // multi-line reads must start on a boundary of their own size
   always_comb begin
      alignErr = 1'b0;
      if (isRead) begin
         if (c0Len == len2) begin
            alignErr = c0Addr[0];
         end else if (c0Len == len4) begin
            alignErr = (c0Addr[1:0] != 2'b00);
         end
      end
   end

   // any valid request counts here, type does not matter
   assign overflowErr = c0Valid && c0Full;
   assign inResetErr = c0Valid && softReset;

   // one registered pulse per kind, several may fire together
   always_ff @(posedge clk) begin
      if (rst) begin
         rdViol <= '0;
      end else begin
         rdViol[rdLen3] <= lenErr;
         rdViol[rdAlign] <= alignErr;
         rdViol[rdOverflow] <= overflowErr;
         rdViol[rdInReset] <= inResetErr;
      end
   end

   // pulses must start clean once reset is released
   rdViolClearAfterReset: assert property (
      @(posedge clk) rst |=> (rdViol == '0)
   );

endmodule

//--- design/violationCounters.sv
// violation counter bank with APB read and clear access
// one saturating counter per kind plus a sticky alarm
`timescale 1ns/1ns

module violationCounters (
   input  logic                        clk,
   input  logic                        rst,
   input  logic [cciPkg::NUM_KINDS-1:0] viol,
   input  logic [cciPkg::APB_AW-1:0]   paddr,
   input  logic                        psel,
   input  logic                        penable,
   input  logic                        pwrite,
   input  logic [31:0]                 pwdata,
   output logic [31:0]                 prdata,
   output logic                        pready,
   output logic                        pslverr,
   output logic                        alarm
);

   import cciPkg::*;

   logic [CNT_W-1:0]     cnt [NUM_KINDS];
   logic [APB_AW-3:0]    idx;
   logic                 idxOk;
   logic                 setupPhase;
   logic                 writeAccess;
   logic [NUM_KINDS-1:0] clrVec;
   logic                 anyNonzero;
   // write payload is not stored, any value clears
   logic                 clrReq;

   // word index, byte offset bits dropped
   assign idx = paddr[APB_AW-1:2];
   assign idxOk = (idx < NUM_KINDS);

   assign setupPhase = psel && !penable;
   assign writeAccess = psel && penable && pwrite;
   assign clrReq = writeAccess && idxOk;

   // no wait states
   assign pready = 1'b1;

   // one-hot clear for the addressed counter
   always_comb begin
      clrVec = '0;
      if (clrReq) begin
         clrVec[idx] = 1'b1;
      end
   end

   always_comb begin
      anyNonzero = 1'b0;
      for (int k = 0; k < NUM_KINDS; k++) begin
         anyNonzero = anyNonzero | (cnt[k] != '0);
      end
   end

   // clear beats increment, count holds at all ones
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int k = 0; k < NUM_KINDS; k++) begin
            cnt[k] <= '0;
         end
      end else begin
         for (int k = 0; k < NUM_KINDS; k++) begin
            if (clrVec[k]) begin
               cnt[k] <= '0;
            end else if (viol[k] && (cnt[k] != '1)) begin
               cnt[k] <= cnt[k] + 1'b1;
            end
         end
      end
   end

   // read data captured at the end of setup, valid through access
   always_ff @(posedge clk) begin
      if (rst) begin
         prdata <= '0;
         pslverr <= 1'b0;
      end else begin
         pslverr <= setupPhase && !idxOk;
         if (setupPhase && idxOk) begin
            prdata <= {{(32-CNT_W){1'b0}}, cnt[idx]};
         end else begin
            prdata <= '0;
         end
      end
   end

   // rises with the first count, drops a cycle after the last clear
   always_ff @(posedge clk) begin
      if (rst) begin
         alarm <= 1'b0;
      end else begin
         alarm <= (|(viol & ~clrVec)) | anyNonzero;
      end
   end

   for (genvar g = 0; g < NUM_KINDS; g++) begin : g_satCheck
      cntHoldsAtMax: assert property (
         @(posedge clk) disable iff (rst)
         ((cnt[g] == '1) && !clrVec[g]) |=> (cnt[g] == '1)
      );
   end

   // error response only while the access phase is open
   slvErrInAccess: assert property (
      @(posedge clk) disable iff (rst)
      pslverr |-> (psel && penable)
   );

endmodule

//--- design/writeBeatTracker.sv
// channel 1 write burst tracker
// follows sop and beat count, flags burst, length, alignment, overflow and reset faults
`timescale 1ns/1ns

module writeBeatTracker (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        c1Valid,
   input  cciPkg::reqType              c1Type,
   input  cciPkg::reqLen               c1Len,
   input  logic [cciPkg::ADDR_W-1:0]   c1Addr,
   input  logic                        c1Sop,
   input  logic                        c1Full,
   input  logic                        softReset,
   output logic [5:0]                  wrViol
);

   import cciPkg::*;

   logic       isWrite;
   logic       sopBeat;
   logic       midBeat;
   // beats still owed by the current burst
   logic [2:0] beatsLeft;
   logic [2:0] beatsNext;
   logic       lenErr;
   logic       alignErr;
   logic       sopErr;
   logic       cutErr;
   logic       overflowErr;
   logic       inResetErr;

   assign isWrite = c1Valid && ((c1Type == wrLineI) || (c1Type == wrLineM));
   assign sopBeat = isWrite && c1Sop;
   assign midBeat = isWrite && !c1Sop;

   // burst rules
   assign lenErr = sopBeat && (c1Len == len3);
   assign cutErr = sopBeat && (beatsLeft != 3'd0);
   assign sopErr = midBeat && (beatsLeft == 3'd0);

   // address checked on the first beat only
   always_comb begin
      alignErr = 1'b0;
      if (sopBeat) begin
         if (c1Len == len2) begin
            alignErr = c1Addr[0];
         end else if (c1Len == len4) begin
            alignErr = (c1Addr[1:0] != 2'b00);
         end
      end
   end

   // any valid beat, whatever its type
   assign overflowErr = c1Valid && c1Full;
   assign inResetErr = c1Valid && softReset;

   // sop restarts the count, even over an unfinished burst
   always_comb begin
      beatsNext = beatsLeft;
      if (sopBeat) begin
         // len3 is treated as a lone beat
         if (c1Len == len3) begin
            beatsNext = 3'd0;
         end else begin
            beatsNext = {1'b0, c1Len};
         end
      end else if (midBeat && (beatsLeft != 3'd0)) begin
         beatsNext = beatsLeft - 3'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         beatsLeft <= 3'd0;
         wrViol <= '0;
      end else begin
         beatsLeft <= beatsNext;
         wrViol[wrLen3 - wrLen3] <= lenErr;
         wrViol[wrAlign - wrLen3] <= alignErr;
         wrViol[wrSop - wrLen3] <= sopErr;
         wrViol[wrOverflow - wrLen3] <= overflowErr;
         wrViol[wrInReset - wrLen3] <= inResetErr;
         wrViol[wrBurstCut - wrLen3] <= cutErr;
      end
   end

   // a burst owes at most three further beats
   beatsLeftBounded: assert property (
      @(posedge clk) disable iff (rst)
      beatsLeft <= 3'd3
   );

endmodule

//--- dv/cciSnifferTb.sv
// coherent link sniffer testbench
// table-driven link traffic, reference violation counts, APB readback and clear
`timescale 1ns/1ns

module cciSnifferTb;

   import cciPkg::*;

   // about 2 x (rows + 300 saturation cycles + 20 APB reads x 2)
   localparam int CYCLE_LIMIT = 1000;

   typedef struct packed {
      logic                 c0Valid;
      reqType               c0Type;
      reqLen                c0Len;
      logic [ADDR_W-1:0]    c0Addr;
      logic                 c0Full;
      logic                 c1Valid;
      reqType               c1Type;
      reqLen                c1Len;
      logic [ADDR_W-1:0]    c1Addr;
      logic                 c1Sop;
      logic                 c1Full;
      logic                 softReset;
      logic [NUM_KINDS-1:0] expMask;
   } stimRow;

   logic clk;
   logic rst;
   logic c0Valid;
   reqType c0Type;
   reqLen c0Len;
   logic [ADDR_W-1:0] c0Addr;
   logic c0Full;
   logic c1Valid;
   reqType c1Type;
   reqLen c1Len;
   logic [ADDR_W-1:0] c1Addr;
   logic c1Sop;
   logic c1Full;
   logic softReset;
   logic [APB_AW-1:0] paddr;
   logic psel;
   logic penable;
   logic pwrite;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic pready;
   logic pslverr;
   logic alarm;

   stimRow stimTable[$];
   logic [CNT_W-1:0] expCnt [NUM_KINDS];
   // reference copy of the beats still owed on channel 1
   int modelBeats;
   int errors;
   int cycles = 0;

   tbClock tbClock_i (.clk(clk), .rst(rst));

   cciSniffer cciSniffer_i (.*);

   function automatic stimRow idleRow();
      stimRow r;
      r = '0;
      return r;
   endfunction

   function automatic logic misaligned(input reqLen l, input logic [ADDR_W-1:0] a);
      return ((l == len2) && a[0]) || ((l == len4) && (a[1:0] != 2'b00));
   endfunction

   // random legal length, never 3 lines
   function automatic reqLen legalLen(input int unsigned pick);
      case (pick % 3)
         0: return len1;
         1: return len2;
         default: return len4;
      endcase
   endfunction

   // expected kinds for one row, straight from the link rules
   task automatic deriveMask(inout stimRow r);
      logic isRd;
      logic isWr;
      logic sop;
      logic mid;
      int lines;
      isRd = r.c0Valid && (r.c0Type inside {rdLineI, rdLineS});
      isWr = r.c1Valid && (r.c1Type inside {wrLineI, wrLineM});
      sop = isWr && r.c1Sop;
      mid = isWr && !r.c1Sop;
      r.expMask = '0;
      r.expMask[rdLen3] = isRd && (r.c0Len == len3);
      r.expMask[rdAlign] = isRd && misaligned(r.c0Len, r.c0Addr);
      r.expMask[rdOverflow] = r.c0Valid && r.c0Full;
      r.expMask[rdInReset] = r.c0Valid && r.softReset;
      r.expMask[wrLen3] = sop && (r.c1Len == len3);
      r.expMask[wrAlign] = sop && misaligned(r.c1Len, r.c1Addr);
      r.expMask[wrSop] = mid && (modelBeats == 0);
      r.expMask[wrOverflow] = r.c1Valid && r.c1Full;
      r.expMask[wrInReset] = r.c1Valid && r.softReset;
      r.expMask[wrBurstCut] = sop && (modelBeats != 0);
      // a 3-line write is tracked as one beat
      case (r.c1Len)
         len2: lines = 2;
         len4: lines = 4;
         default: lines = 1;
      endcase
      if (sop) begin
         modelBeats = lines - 1;
      end else if (mid && (modelBeats != 0)) begin
         modelBeats--;
      end
   endtask

   task automatic pushRead(input reqType t, input reqLen l, input logic [ADDR_W-1:0] a,
         input logic full, input logic sr);
      stimRow r;
      r = idleRow();
      r.c0Valid = 1'b1;
      r.c0Type = t;
      r.c0Len = l;
      r.c0Addr = a;
      r.c0Full = full;
      r.softReset = sr;
      deriveMask(r);
      stimTable.push_back(r);
   endtask

   task automatic pushWrite(input reqType t, input reqLen l, input logic [ADDR_W-1:0] a,
         input logic sop, input logic full, input logic sr);
      stimRow r;
      r = idleRow();
      r.c1Valid = 1'b1;
      r.c1Type = t;
      r.c1Len = l;
      r.c1Addr = a;
      r.c1Sop = sop;
      r.c1Full = full;
      r.softReset = sr;
      deriveMask(r);
      stimTable.push_back(r);
   endtask

   task automatic driveRow(input stimRow r);
      c0Valid = r.c0Valid;
      c0Type = r.c0Type;
      c0Len = r.c0Len;
      c0Addr = r.c0Addr;
      c0Full = r.c0Full;
      c1Valid = r.c1Valid;
      c1Type = r.c1Type;
      c1Len = r.c1Len;
      c1Addr = r.c1Addr;
      c1Sop = r.c1Sop;
      c1Full = r.c1Full;
      softReset = r.softReset;
   endtask

   // one row per cycle, expected counts saturate like the hardware
   task automatic applyTable();
      int k;
      foreach (stimTable[i]) begin
         @(posedge clk);
         #5;
         driveRow(stimTable[i]);
         for (k = 0; k < NUM_KINDS; k++) begin
            if (stimTable[i].expMask[k] && (expCnt[k] != '1)) begin
               expCnt[k] = expCnt[k] + 1'b1;
            end
         end
      end
      stimTable.delete();
      @(posedge clk);
      #5;
      driveRow(idleRow());
      // pulse one cycle later, count the cycle after
      repeat (3) @(posedge clk);
   endtask

   task automatic checkCount(input string name, input logic [CNT_W-1:0] got,
         input logic [CNT_W-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // setup, one access cycle, then back to idle
   task automatic apbAccess(input int k, input logic wr, output logic [31:0] data,
         output logic err);
      @(posedge clk);
      #5;
      paddr = APB_AW'(4 * k);
      pwrite = wr;
      pwdata = $urandom();
      psel = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #5;
      penable = 1'b1;
      #10;
      // zero wait states, ready in the first access cycle
      checkFlag("pready", pready, 1'b1);
      data = prdata;
      err = pslverr;
      @(posedge clk);
      #5;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   task automatic readAll();
      logic [31:0] data;
      logic err;
      int k;
      for (k = 0; k < NUM_KINDS; k++) begin
         apbAccess(k, 1'b0, data, err);
         checkCount($sformatf("counter %0d", k), data[CNT_W-1:0], expCnt[k]);
         checkFlag($sformatf("prdata upper bits %0d", k), |data[31:CNT_W], 1'b0);
         checkFlag("pslverr", err, 1'b0);
      end
   endtask

   function automatic logic anyExpected();
      logic any;
      any = 1'b0;
      for (int k = 0; k < NUM_KINDS; k++) begin
         any = any | (expCnt[k] != '0);
      end
      return any;
   endfunction

   // watchdog
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout, no end of test after %0d cycles", CYCLE_LIMIT);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   initial begin : mainSeq
      logic [31:0] data;
      logic err;
      logic [ADDR_W-1:0] a;
      int i;
      int k;
      errors = 0;
      modelBeats = 0;
      for (k = 0; k < NUM_KINDS; k++) begin
         expCnt[k] = '0;
      end
      void'($urandom(32'h4134f3ce));
      driveRow(idleRow());
      paddr = '0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      pwdata = '0;
      @(negedge rst);
      checkFlag("alarm", alarm, 1'b0);

      // read rules, write type on channel 0 is ignored
      pushRead(rdLineI, len3, 42'h100, 1'b0, 1'b0);
      pushRead(rdLineS, len2, 42'h101, 1'b0, 1'b0);
      pushRead(rdLineI, len4, 42'h102, 1'b0, 1'b0);
      pushRead(rdLineS, len4, 42'h104, 1'b0, 1'b0);
      pushRead(rdLineI, len2, 42'h106, 1'b0, 1'b0);
      pushRead(rdLineI, len1, 42'h107, 1'b0, 1'b0);
      pushRead(wrLineM, len3, 42'h103, 1'b0, 1'b0);
      pushRead(rdLineS, len3, 42'h200, 1'b0, 1'b0);
      applyTable();
      readAll();
      checkFlag("alarm", alarm, 1'b1);

      // clean 2 and 4 beat bursts
      pushWrite(wrLineI, len2, 42'h10, 1'b1, 1'b0, 1'b0);
      pushWrite(wrLineI, len2, 42'h10, 1'b0, 1'b0, 1'b0);
      pushWrite(wrLineM, len4, 42'h20, 1'b1, 1'b0, 1'b0);
      for (i = 0; i < 3; i++) begin
         pushWrite(wrLineM, len4, 42'h20, 1'b0, 1'b0, 1'b0);
      end
      // missing sop
      pushWrite(wrLineM, len1, 42'h30, 1'b0, 1'b0, 1'b0);
      // early sop cuts a 4-beat burst, new burst completes
      pushWrite(wrLineI, len4, 42'h40, 1'b1, 1'b0, 1'b0);
      pushWrite(wrLineI, len4, 42'h40, 1'b0, 1'b0, 1'b0);
      pushWrite(wrLineI, len2, 42'h50, 1'b1, 1'b0, 1'b0);
      pushWrite(wrLineI, len2, 42'h50, 1'b0, 1'b0, 1'b0);
      pushWrite(wrLineM, len3, 42'h60, 1'b1, 1'b0, 1'b0);
      // misaligned sop
      pushWrite(wrLineM, len4, 42'h72, 1'b1, 1'b0, 1'b0);
      for (i = 0; i < 3; i++) begin
         pushWrite(wrLineM, len4, 42'h72, 1'b0, 1'b0, 1'b0);
      end
      pushWrite(rdLineI, len1, 42'h80, 1'b0, 1'b0, 1'b0);
      // legal random filler
      for (i = 0; i < 8; i++) begin
         a = ADDR_W'({$urandom(), $urandom()});
         a[1:0] = 2'b00;
         pushRead(($urandom() & 1) ? rdLineS : rdLineI, legalLen($urandom()), a, 1'b0, 1'b0);
         pushWrite(wrLineM, len1, a, 1'b1, 1'b0, 1'b0);
      end
      applyTable();
      readAll();

      // overflow, soft reset and several rules at once
      pushRead(rdLineS, len1, 42'h300, 1'b1, 1'b0);
      pushRead(rdLineI, len1, 42'h300, 1'b0, 1'b1);
      pushRead(wrLineI, len1, 42'h300, 1'b1, 1'b1);
      pushRead(rdLineS, len2, 42'h301, 1'b1, 1'b1);
      pushWrite(wrLineI, len1, 42'h310, 1'b1, 1'b1, 1'b0);
      pushWrite(wrLineM, len1, 42'h311, 1'b1, 1'b0, 1'b1);
      pushWrite(wrLineI, len3, 42'h313, 1'b1, 1'b1, 1'b1);
      applyTable();
      readAll();

      // saturation
      for (i = 0; i < 300; i++) begin
         pushRead(rdLineI, len3, 42'h400, 1'b0, 1'b0);
      end
      applyTable();
      readAll();
      apbAccess(rdLen3, 1'b0, data, err);
      checkCount("rdLen3 saturated", data[CNT_W-1:0], 8'hff);

      // clear one by one, alarm follows a cycle behind
      for (k = 0; k < NUM_KINDS; k++) begin
         apbAccess(k, 1'b1, data, err);
         expCnt[k] = '0;
         @(posedge clk);
         #5;
         checkFlag("alarm", alarm, anyExpected());
      end
      readAll();
      checkFlag("alarm", alarm, 1'b0);
      apbAccess(NUM_KINDS, 1'b0, data, err);
      checkFlag("pslverr", err, 1'b1);
      checkCount("prdata", data[CNT_W-1:0], '0);
      checkFlag("prdata upper bits", |data[31:CNT_W], 1'b0);

      $display("sniffer checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

//--- dv/tbClock.sv
// testbench clock and reset source
// 40 ns clock, reset held for the first four cycles
`timescale 1ns/1ns

module tbClock (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // released just after an edge, like every other input
   initial begin
      rst = 1'b1;
      repeat (4) @(posedge clk);
      #5;
      rst = 1'b0;
   end

endmodule

//--- flist.f
design/cciPkg.sv
design/readReqRules.sv
design/writeBeatTracker.sv
design/violationCounters.sv
design/cciSniffer.sv
dv/tbClock.sv
dv/cciSnifferTb.sv

//--- run.sh
#!/bin/sh
# build and run the sniffer testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f flist.f \
   --top-module cciSnifferTb -o simv &&
out="$(./obj_dir/simv)" &&
echo "$out" &&
echo "$out" | grep -qx "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
